// ==== rtl/evb_pkg.sv ====
package evb_pkg;

    // Buffer geometry. The tree logic assumes exactly eight ways
    localparam int evb_ways       = 8;
    localparam int evb_way_bits   = 3;
    localparam int plru_bits      = 7;

    // One transfer moves a whole cache line
    localparam int line_addr_bits = 12;
    localparam int line_bits      = 128;

    typedef logic [line_addr_bits-1:0] line_addr_t;
    typedef logic [line_bits-1:0]      line_t;
    typedef logic [evb_way_bits-1:0]   way_idx_t;
    typedef logic [plru_bits-1:0]      plru_t;

    // Wishbone classic request, master to slave
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        line_addr_t addr;
        line_t      wdata;
    } wb_req_t;

    // Wishbone classic response, slave to master
    typedef struct packed {
        logic  ack;
        line_t rdata;
    } wb_rsp_t;

    typedef struct packed {
        logic       valid;
        logic       dirty;     // Line is newer than the copy in memory
        line_addr_t tag;
        line_t      data;
    } evb_entry_t;

    typedef enum logic [2:0] {
        st_idle,               // Serve cache requests or start a background drain
        st_fetch,              // Read miss passed through to memory
        st_return,
        st_write_back,
        st_fill,
        st_ack                 // Stall one cycle while the cache drops stb
    } evb_state_e;

    // Command to the entry array, applied at the next clock edge
    typedef enum logic [1:0] {
        op_none,
        op_fill,
        op_clean
    } array_op_e;

endpackage

// ==== rtl/plru_tree.sv ====
`timescale 1ns/1ps

module plru_tree import evb_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     touch,
    input  way_idx_t touch_way,
    output way_idx_t victim
);

    // Bit 0 is the root, bits 1 and 2 pick a pair of pairs, bits 3 to 6 pick within a pair
    plru_t tree_q;
    plru_t tree_d;
    logic [1:0] victim_pair;

    // Walk from the root down to the pair that holds the victim
    assign victim_pair = {tree_q[0], tree_q[0] ? tree_q[2] : tree_q[1]};
    assign victim      = {victim_pair, tree_q[3 + victim_pair]};

    // Point every bit on the touched path away from the touched way
    always_comb begin
        tree_d    = tree_q;
        tree_d[0] = ~touch_way[2];
        if (touch_way[2]) begin
            tree_d[2] = ~touch_way[1];
        end else begin
            tree_d[1] = ~touch_way[1];
        end
        tree_d[3 + touch_way[2:1]] = ~touch_way[0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tree_q <= '0;          // First victim is way 0
        end else if (touch) begin
            tree_q <= tree_d;
        end
    end

endmodule

// ==== rtl/evb_entry_array.sv ====
`timescale 1ns/1ps

module evb_entry_array import evb_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  array_op_e     op,
    input  way_idx_t      way,
    input  line_addr_t    addr,
    input  line_t         wdata,
    output logic [7:0]    hits,
    output logic [7:0]    dirty_vec,
    output evb_entry_t    sel_entry
);

    logic [evb_ways-1:0] valid_q;
    logic [evb_ways-1:0] dirty_q;
    line_addr_t          tag_q [evb_ways];
    line_t               data_q [evb_ways];

    // Status bits per way
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (op)
                op_fill: begin
                    valid_q[way] <= 1'b1;
                    dirty_q[way] <= 1'b1;       // A line from the cache always needs a write-back
                end
                op_clean: begin
                    dirty_q[way] <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (op == op_fill) begin
            tag_q[way]  <= addr;
            data_q[way] <= wdata;
        end
    end

    // Fully associative lookup against every valid tag
    always_comb begin
        for (int i = 0; i < evb_ways; i++) begin
            hits[i] = valid_q[i] && (tag_q[i] == addr);
        end
    end

    assign dirty_vec = dirty_q;

    assign sel_entry = '{
        valid: valid_q[way],
        dirty: dirty_q[way],
        tag:   tag_q[way],
        data:  data_q[way]
    };

endmodule

// ==== rtl/eviction_buffer_controller.sv ====
`timescale 1ns/1ps

module eviction_buffer_controller import evb_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  wb_req_t       cpu_req,
    output wb_rsp_t       cpu_rsp,
    output wb_req_t       mem_req,
    input  wb_rsp_t       mem_rsp,
    input  logic [7:0]    hits,
    input  logic [7:0]    dirty_vec,
    input  evb_entry_t    sel_entry,
    input  way_idx_t      victim,
    output array_op_e     op,
    output way_idx_t      way,
    output line_addr_t    addr,
    output line_t         wdata,
    output logic          touch,
    output way_idx_t      touch_way
);

    evb_state_e state_q;
    evb_state_e state_d;
    way_idx_t   way_q;
    way_idx_t   way_d;
    logic       drain_q;
    logic       drain_d;
    logic       ack_q;
    logic       ack_d;
    line_t      rdata_q;
    line_t      rdata_d;

    logic       cpu_active;
    logic       hit_any;
    way_idx_t   hit_way;
    way_idx_t   drain_way;
    way_idx_t   target_way;

    function automatic way_idx_t lowest_set(input logic [evb_ways-1:0] vec);
        way_idx_t idx;
        idx = '0;
        for (int i = evb_ways - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = way_idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign cpu_active = cpu_req.cyc && cpu_req.stb;
    assign hit_any    = |hits;
    assign hit_way    = lowest_set(hits);
    assign drain_way  = lowest_set(dirty_vec);
    assign target_way = hit_any ? hit_way : victim;    // A write hit merges into its entry

    // The cache holds address and data until ack, so they feed the array directly
    assign addr      = cpu_req.addr;
    assign wdata     = cpu_req.wdata;
    assign touch_way = way;

    assign cpu_rsp = '{ack: ack_q, rdata: rdata_q};

    always_comb begin
        state_d = state_q;
        way_d   = way_q;
        drain_d = drain_q;
        ack_d   = 1'b0;
        rdata_d = rdata_q;
        op      = op_none;
        touch   = 1'b0;
        way     = way_q;

        case (state_q)
            st_idle: begin
                if (cpu_active) begin
                    way   = target_way;
                    way_d = target_way;
                    if (!cpu_req.we) begin
                        if (hit_any) begin
                            rdata_d = sel_entry.data;
                            ack_d   = 1'b1;
                            touch   = 1'b1;
                            state_d = st_ack;
                        end else begin
                            state_d = st_fetch;
                        end
                    end else if (sel_entry.valid && sel_entry.dirty) begin
                        drain_d = 1'b0;             // Old line must reach memory before the fill
                        state_d = st_write_back;
                    end else begin
                        op      = op_fill;
                        touch   = 1'b1;
                        ack_d   = 1'b1;
                        state_d = st_ack;
                    end
                end else if (|dirty_vec) begin
                    way     = drain_way;
                    way_d   = drain_way;
                    drain_d = 1'b1;
                    state_d = st_write_back;
                end
            end
            st_fetch: begin
                if (mem_rsp.ack) begin
                    rdata_d = mem_rsp.rdata;        // Passed through, never allocated
                    ack_d   = 1'b1;
                    state_d = st_return;
                end
            end
            st_return: begin
                state_d = st_ack;
            end
            st_write_back: begin
                if (mem_rsp.ack) begin
                    if (drain_q) begin
                        op      = op_clean;
                        state_d = st_idle;
                    end else begin
                        ack_d   = 1'b1;
                        state_d = st_fill;
                    end
                end
            end
            st_fill: begin
                op      = op_fill;
                touch   = 1'b1;
                state_d = st_ack;
            end
            st_ack: begin
                state_d = st_idle;
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    // Memory master, held steady by the state until ack
    always_comb begin
        mem_req = '0;
        case (state_q)
            st_fetch: begin
                mem_req.cyc  = 1'b1;
                mem_req.stb  = 1'b1;
                mem_req.addr = cpu_req.addr;
            end
            st_write_back: begin
                mem_req.cyc   = 1'b1;
                mem_req.stb   = 1'b1;
                mem_req.we    = 1'b1;
                mem_req.addr  = sel_entry.tag;
                mem_req.wdata = sel_entry.data;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            way_q   <= '0;
            drain_q <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            way_q   <= way_d;
            drain_q <= drain_d;
            ack_q   <= ack_d;
        end
    end

    always_ff @(posedge clk) begin
        rdata_q <= rdata_d;
    end

endmodule

// ==== rtl/eviction_buffer.sv ====
`timescale 1ns/1ps

module eviction_buffer import evb_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  wb_req_t cpu_req,
    output wb_rsp_t cpu_rsp,
    output wb_req_t mem_req,
    input  wb_rsp_t mem_rsp
);

    logic [evb_ways-1:0] hits;
    logic [evb_ways-1:0] dirty_vec;
    evb_entry_t          sel_entry;
    way_idx_t            victim;
    array_op_e           array_op;
    way_idx_t            way;
    line_addr_t          addr;
    line_t               wdata;
    logic                touch;
    way_idx_t            touch_way;

    eviction_buffer_controller controller (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_req   (cpu_req),
        .cpu_rsp   (cpu_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .hits      (hits),
        .dirty_vec (dirty_vec),
        .sel_entry (sel_entry),
        .victim    (victim),
        .op        (array_op),
        .way       (way),
        .addr      (addr),
        .wdata     (wdata),
        .touch     (touch),
        .touch_way (touch_way)
    );

    evb_entry_array entry_array (
        .clk       (clk),
        .arst_n    (arst_n),
        .op        (array_op),
        .way       (way),
        .addr      (addr),
        .wdata     (wdata),
        .hits      (hits),
        .dirty_vec (dirty_vec),
        .sel_entry (sel_entry)
    );

    plru_tree plru (
        .clk       (clk),
        .arst_n    (arst_n),
        .touch     (touch),
        .touch_way (touch_way),
        .victim    (victim)
    );

endmodule

// ==== tests/eviction_buffer_assert.sv ====
`timescale 1ns/1ps

module eviction_buffer_assert import evb_pkg::*; (
    input logic    clk,
    input logic    arst_n,
    input wb_req_t cpu_req,
    input wb_rsp_t cpu_rsp,
    input wb_req_t mem_req,
    input wb_rsp_t mem_rsp
);

    int failures = 0;

    cpu_ack_needs_stb: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_rsp.ack |-> cpu_req.cyc && cpu_req.stb)
        else begin
            $error("Cache port ack without a strobe");
            failures++;
        end

    mem_ack_needs_stb: assert property (@(posedge clk) disable iff (!arst_n)
        mem_rsp.ack |-> mem_req.cyc && mem_req.stb)
        else begin
            $error("Memory port ack without a strobe");
            failures++;
        end

    // A request may only change once it has been acked
    mem_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req.stb && !mem_rsp.ack |=> $stable(mem_req))
        else begin
            $error("Memory request changed before its ack");
            failures++;
        end

    cpu_ack_single: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_rsp.ack |=> !cpu_rsp.ack)
        else begin
            $error("Cache port acked two cycles in a row");
            failures++;
        end

endmodule

bind eviction_buffer eviction_buffer_assert protocol_checks (
    .clk     (clk),
    .arst_n  (arst_n),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
);

// ==== tests/tb_eviction_buffer.sv ====
`timescale 1ns/1ps

module tb_eviction_buffer import evb_pkg::*; ();

    logic        clk;
    logic        arst_n;
    wb_req_t     cpu_req;
    wb_rsp_t     cpu_rsp;
    wb_req_t     mem_req;
    wb_rsp_t     mem_rsp;

    line_t       mem_lines [1 << line_addr_bits];
    line_t       shadow [line_addr_t];          // Latest line the cache wrote per address
    line_addr_t  addr_pool [20];
    line_t       exp_q [$];
    line_t       got_q [$];
    logic [15:0] lfsr_state = 16'd76;
    int          mismatches = 0;
    int          timeouts = 0;
    int          reads_checked = 0;

    eviction_buffer UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
        end
        return r;
    endfunction

    function automatic line_t random_line();
        line_t r;
        for (int k = 0; k < 4; k++) begin
            r[k*32 +: 32] = take_bits(32);
        end
        return r;
    endfunction

    // Every word of the power-up memory contents carries its full line address
    function automatic line_t init_line(input line_addr_t a);
        line_t r;
        for (int k = 0; k < 4; k++) begin
            r[k*32 +: 32] = {4'(k), 8'hC3, 8'h5A, a};
        end
        return r;
    endfunction

    function automatic line_t expected_line(input line_addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return init_line(a);
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic check_read(input line_t exp, input line_t got);
        reads_checked++;
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: cpu_rsp.rdata expected %h got %h", $time, exp, got);
        end
    endtask

    task automatic check_memory(input line_addr_t a, input line_t exp);
        if (mem_lines[a] !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: mem_lines[%h] expected %h got %h",
                     $time, a, exp, mem_lines[a]);
        end
    endtask

    task automatic check_all_memory();
        foreach (shadow[a]) begin
            check_memory(a, shadow[a]);
        end
    endtask

    // One cache transfer that also notes any memory cycle while it waits
    task automatic cpu_access(input logic we, input line_addr_t a, input line_t d,
                              output line_t rd, output logic mem_used);
        int   cycles;
        logic acked;
        cycles   = 0;
        acked    = 1'b0;
        mem_used = 1'b0;
        rd       = '0;
        @(posedge clk);
        #1;
        cpu_req = '{cyc: 1'b1, stb: 1'b1, we: we, addr: a, wdata: d};
        while (!acked && cycles < 200) begin
            @(negedge clk);
            if (mem_req.cyc && mem_req.stb) begin
                mem_used = 1'b1;
            end
            if (cpu_rsp.ack) begin
                acked = 1'b1;
                rd    = cpu_rsp.rdata;
            end
            cycles++;
        end
        @(posedge clk);
        #1;
        cpu_req = '0;
        if (!acked) begin
            timeouts++;
            $display("Timeout at %0t: the cache port never acked line %h", $time, a);
        end
    endtask

    task automatic write_line(input line_addr_t a, input line_t d);
        line_t rd;
        logic  mem_used;
        cpu_access(1'b1, a, d, rd, mem_used);
        shadow[a] = d;
    endtask

    task automatic read_line(input line_addr_t a, output logic mem_used);
        line_t exp;
        line_t rd;
        exp = expected_line(a);
        cpu_access(1'b0, a, '0, rd, mem_used);
        exp_q.push_back(exp);
        got_q.push_back(rd);
    endtask

    // Drained once the memory port has stayed idle for a while
    task automatic wait_for_drain();
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 16 && cycles < 2000) begin
            @(negedge clk);
            quiet = mem_req.cyc ? 0 : quiet + 1;
            cycles++;
        end
        if (quiet < 16) begin
            timeouts++;
            $display("Timeout at %0t: the buffer kept the memory port busy", $time);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin : memory_slave
        wb_req_t req;
        int      delay;
        mem_rsp = '0;
        for (int i = 0; i < (1 << line_addr_bits); i++) begin
            mem_lines[i] = init_line(line_addr_t'(i));
        end
        forever begin
            @(negedge clk);
            if (mem_req.cyc && mem_req.stb) begin
                req   = mem_req;
                delay = 1 + int'(take_bits(2));     // One to four cycles
                repeat (delay) @(posedge clk);
                #1;
                if (req.we) begin
                    mem_lines[req.addr] = req.wdata;
                end
                mem_rsp = '{ack: 1'b1, rdata: req.we ? '0 : mem_lines[req.addr]};
                @(posedge clk);
                #1;
                mem_rsp = '0;
            end
        end
    end

    initial begin : read_compare
        forever begin
            @(posedge clk);
            while (got_q.size() > 0) begin
                check_read(exp_q.pop_front(), got_q.pop_front());
            end
        end
    end

    initial begin : stimulus
        logic       mem_used;
        line_addr_t a;
        cpu_req = '0;
        arst_n  = 1'b0;
        for (int i = 0; i < 20; i++) begin
            addr_pool[i] = line_addr_t'(12'h011 + i * 12'h0A3);
        end
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_bit("cpu_rsp.ack", 1'b0, cpu_rsp.ack);
        check_bit("mem_req.cyc", 1'b0, mem_req.cyc);

        read_line(addr_pool[0], mem_used);      // The buffer is still empty so this read misses
        check_bit("memory cycle on miss", 1'b1, mem_used);

        // The written line is drained first and stays in the buffer as a clean entry
        write_line(addr_pool[1], random_line());
        wait_for_drain();
        read_line(addr_pool[1], mem_used);
        check_bit("memory cycle on hit", 1'b0, mem_used);

        for (int i = 0; i < 5; i++) begin
            write_line(addr_pool[2], random_line());
        end
        wait_for_drain();
        check_memory(addr_pool[2], shadow[addr_pool[2]]);

        // Twelve distinct lines overflow the eight ways
        for (int i = 3; i < 15; i++) begin
            write_line(addr_pool[i], random_line());
        end
        for (int i = 3; i < 15; i++) begin
            read_line(addr_pool[i], mem_used);
        end
        wait_for_drain();
        check_all_memory();

        for (int n = 0; n < 400; n++) begin
            a = addr_pool[take_bits(5) % 20];
            if (take_bits(1)) begin
                write_line(a, random_line());
            end else begin
                read_line(a, mem_used);
            end
        end
        wait_for_drain();
        check_all_memory();
        repeat (2) @(posedge clk);

        $display("Reads checked %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
                 reads_checked, mismatches, timeouts, UUT.protocol_checks.failures);
        if (mismatches == 0 && timeouts == 0 && UUT.protocol_checks.failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/evb_pkg.sv
rtl/plru_tree.sv
rtl/evb_entry_array.sv
rtl/eviction_buffer_controller.sv
rtl/eviction_buffer.sv
tests/eviction_buffer_assert.sv
tests/tb_eviction_buffer.sv

// ==== Bender.yml ====
package:
  name: eviction_buffer

sources:
  - rtl/evb_pkg.sv
  - rtl/plru_tree.sv
  - rtl/evb_entry_array.sv
  - rtl/eviction_buffer_controller.sv
  - rtl/eviction_buffer.sv
  - target: test
    files:
      - tests/eviction_buffer_assert.sv
      - tests/tb_eviction_buffer.sv
